// ==== sched_pkg.sv ====
package sched_pkg;

  // Default geometry of the processing-element array
  parameter int unsigned ARRAY_HEIGHT = 4;
  parameter int unsigned ARRAY_WIDTH  = 4;
  parameter int unsigned PIPE_REGS    = 2;

  // An X or Z tile covers one full pipeline pass of every PE row
  parameter int unsigned TOT_DEPTH = ARRAY_HEIGHT * (PIPE_REGS + 1);

  // Width of every tile iteration counter and iteration-count input
  parameter int unsigned ITER_W = 16;

  typedef logic [ITER_W-1:0] iter_cnt_t;

  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    LOAD_W,
    WAIT
  } sched_phase_e;

endpackage

// ==== sched_phase_ctrl.sv ====
`timescale 1ns/1ns

module sched_phase_ctrl #(
  parameter int unsigned NumPipeRegs = sched_pkg::PIPE_REGS
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic start_i,
  input  logic gemm_sel_i,
  input  logic x_full_i,
  input  logic z_loaded_i,
  input  logic w_valid_i,
  input  logic w_done_i,
  input  logic y_check_i,
  input  logic z_window_end_i,
  output logic load_w_go_o,
  output logic shift_go_o,
  output logic pad_setup_o,
  output logic start_comp_o,
  output logic stall_o,
  output logic reg_enable_o,
  output logic busy_o,
  output logic w_loaded_o
);

  import sched_pkg::*;

  localparam int unsigned WaitW = $clog2(NumPipeRegs + 1);

  sched_phase_e     phase_q;
  sched_phase_e     phase_d;
  logic [WaitW-1:0] wait_cnt_q;
  logic             start;
  logic             stall;
  logic             wait_last;
  logic             finish;
  logic             first_load_q;
  logic             computing_q;
  logic             reg_enable_q;

  assign start     = (phase_q == IDLE) && start_i;
  assign wait_last = wait_cnt_q == WaitW'(NumPipeRegs);
  assign finish    = (phase_q == LOAD_W) && (phase_d == IDLE);

  // Hold the engine when the next W row is missing or the Y rows for the
  // upcoming result window are not loaded yet
  assign stall = (phase_q == LOAD_W) &&
                 ((!w_valid_i && !w_done_i) || (y_check_i && !z_loaded_i));

  always_comb begin
    phase_d = phase_q;
    unique case (phase_q)
      IDLE: begin
        if (start_i) begin
          phase_d = PRELOAD;
        end
      end
      PRELOAD: begin
        // A GEMM with Y also needs the first Y rows in place
        if (x_full_i && (z_loaded_i || !gemm_sel_i)) begin
          phase_d = LOAD_W;
        end
      end
      LOAD_W: begin
        if (w_done_i && z_window_end_i) begin
          phase_d = IDLE;
        end else if (!stall) begin
          phase_d = WAIT;
        end
      end
      WAIT: begin
        if (wait_last && !stall) begin
          phase_d = LOAD_W;
        end
      end
      default: phase_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= IDLE;
    end else if (clear_i) begin
      phase_q <= IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  // Paces W loads so the engine pipeline drains between two rows
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_cnt_q <= '0;
    end else if (clear_i || start) begin
      wait_cnt_q <= '0;
    end else if (shift_go_o) begin
      wait_cnt_q <= wait_last ? '0 : wait_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
    end else if (clear_i || start) begin
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
    end else begin
      if (load_w_go_o) begin
        first_load_q <= 1'b0;
      end
      if (pad_setup_o) begin
        computing_q <= 1'b1;
      end else if (finish) begin
        computing_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_enable_q <= 1'b0;
    end else if (clear_i) begin
      reg_enable_q <= 1'b0;
    end else begin
      reg_enable_q <= computing_q && !stall;
    end
  end

  assign load_w_go_o  = (phase_q == LOAD_W) && !stall;
  assign shift_go_o   = ((phase_q == LOAD_W) || (phase_q == WAIT)) && !stall;
  assign pad_setup_o  = (phase_q == PRELOAD) && (phase_d == LOAD_W);
  assign start_comp_o = first_load_q && load_w_go_o;
  assign stall_o      = stall;
  assign reg_enable_o = reg_enable_q;
  assign busy_o       = phase_q != IDLE;
  assign w_loaded_o   = load_w_go_o;

  // A stall always blocks the exit path, since it requires W to be unfinished
  a_stall_holds_phase: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stall_o && !clear_i) |=> (phase_q == LOAD_W))
    else $error("phase left LOAD_W during a stall");

endmodule

// ==== x_tile_seq.sv ====
`timescale 1ns/1ns

module x_tile_seq #(
  parameter int unsigned Height = sched_pkg::ARRAY_HEIGHT,
  parameter int unsigned Width  = sched_pkg::ARRAY_WIDTH,
  parameter int unsigned Depth  = sched_pkg::TOT_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                start_i,
  input  logic                x_empty_i,
  input  logic                x_full_i,
  input  logic                x_valid_i,
  input  logic                shift_go_i,
  input  logic                load_w_go_i,
  input  logic                stall_i,
  input  sched_pkg::iter_cnt_t x_cols_iter_i,
  input  sched_pkg::iter_cnt_t x_rows_iter_i,
  input  sched_pkg::iter_cnt_t w_cols_iter_i,
  input  sched_pkg::iter_cnt_t x_cols_lftovr_i,
  input  sched_pkg::iter_cnt_t x_rows_lftovr_i,
  output logic                x_load_o,
  output logic                x_h_shift_o,
  output logic                x_rst_w_index_o,
  output logic                x_last_o,
  output sched_pkg::iter_cnt_t x_height_o,
  output sched_pkg::iter_cnt_t x_width_o
);

  import sched_pkg::*;

  localparam int unsigned ShiftW = (Height > 1) ? $clog2(Height) : 1;

  iter_cnt_t         x_cols_q;
  iter_cnt_t         x_w_q;
  iter_cnt_t         x_rows_q;
  logic [ShiftW-1:0] shift_cnt_q;
  logic              restart;
  logic              cols_last;
  logic              w_last;
  logic              rows_last;
  logic              shift_last;
  logic              x_done_q;
  logic              x_reload_q;

  assign restart    = clear_i || start_i;
  assign cols_last  = x_cols_q == x_cols_iter_i - 1'b1;
  assign w_last     = x_w_q == w_cols_iter_i - 1'b1;
  assign rows_last  = x_rows_q == x_rows_iter_i - 1'b1;
  assign shift_last = shift_cnt_q == ShiftW'(Height - 1);

  // Each empty pulse retires one X tile: columns first, then one pass per
  // W column, then the next block of X rows
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_cols_q <= '0;
      x_w_q    <= '0;
      x_rows_q <= '0;
    end else if (restart) begin
      x_cols_q <= '0;
      x_w_q    <= '0;
      x_rows_q <= '0;
    end else if (x_empty_i && !x_done_q) begin
      x_cols_q <= cols_last ? '0 : x_cols_q + 1'b1;
      if (cols_last) begin
        x_w_q <= w_last ? '0 : x_w_q + 1'b1;
        if (w_last) begin
          x_rows_q <= x_rows_q + 1'b1;
        end
      end
    end
  end

  assign x_last_o = x_empty_i && !x_done_q && cols_last && w_last && rows_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_done_q <= 1'b0;
    end else if (restart) begin
      x_done_q <= 1'b0;
    end else if (x_last_o) begin
      x_done_q <= 1'b1;
    end
  end

  // Tracks which PE row receives the next W row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_cnt_q <= '0;
    end else if (restart) begin
      shift_cnt_q <= '0;
    end else if (load_w_go_i) begin
      shift_cnt_q <= shift_last ? '0 : shift_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_reload_q <= 1'b0;
    end else if (clear_i) begin
      x_reload_q <= 1'b0;
    end else if (start_i || x_empty_i) begin
      x_reload_q <= 1'b1;
    end else if (x_full_i) begin
      x_reload_q <= 1'b0;
    end
  end

  // Refill writes wait out engine stalls
  assign x_load_o        = x_reload_q && !x_full_i && x_valid_i && !stall_i;
  assign x_h_shift_o     = shift_go_i;
  assign x_rst_w_index_o = load_w_go_i && x_full_i && (shift_last || x_empty_i);

  assign x_height_o = (cols_last && x_cols_lftovr_i != '0) ?
                      x_cols_lftovr_i : iter_cnt_t'(Depth);
  assign x_width_o  = (rows_last && x_rows_lftovr_i != '0) ?
                      x_rows_lftovr_i : iter_cnt_t'(Width);

  // The buffer raises empty for a single cycle per drained tile
  a_empty_is_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_empty_i |=> !x_empty_i)
    else $error("x_empty_i held for two cycles");

endmodule

// ==== w_tile_seq.sv ====
`timescale 1ns/1ns

module w_tile_seq #(
  parameter int unsigned Height = sched_pkg::ARRAY_HEIGHT
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                start_i,
  input  logic                w_valid_i,
  input  logic                load_w_go_i,
  input  logic                shift_go_i,
  input  sched_pkg::iter_cnt_t w_rows_iter_i,
  input  sched_pkg::iter_cnt_t w_cols_iter_i,
  input  sched_pkg::iter_cnt_t x_rows_iter_i,
  input  sched_pkg::iter_cnt_t w_rows_lftovr_i,
  input  sched_pkg::iter_cnt_t w_cols_lftovr_i,
  output logic                w_load_o,
  output logic                w_shift_o,
  output logic                w_done_o,
  output logic                w_col_step_o,
  output sched_pkg::iter_cnt_t w_height_o,
  output sched_pkg::iter_cnt_t w_width_o
);

  import sched_pkg::*;

  iter_cnt_t w_rows_q;
  iter_cnt_t w_cols_q;
  iter_cnt_t w_mat_q;
  logic      restart;
  logic      row_step;
  logic      rows_last;
  logic      cols_last;
  logic      mat_step;
  logic      w_done_q;

  assign restart   = clear_i || start_i;
  assign rows_last = w_rows_q == w_rows_iter_i - 1'b1;
  assign cols_last = w_cols_q == w_cols_iter_i - 1'b1;
  assign row_step  = w_load_o && w_valid_i;
  assign mat_step  = w_col_step_o && cols_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_rows_q <= '0;
      w_cols_q <= '0;
      w_mat_q  <= '0;
    end else if (restart) begin
      w_rows_q <= '0;
      w_cols_q <= '0;
      w_mat_q  <= '0;
    end else if (row_step) begin
      w_rows_q <= rows_last ? '0 : w_rows_q + 1'b1;
      if (rows_last) begin
        w_cols_q <= cols_last ? '0 : w_cols_q + 1'b1;
      end
      if (mat_step) begin
        w_mat_q <= w_mat_q + 1'b1;
      end
    end
  end

  // W is reused once for every block of X rows
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_done_q <= 1'b0;
    end else if (restart) begin
      w_done_q <= 1'b0;
    end else if (mat_step && w_mat_q == x_rows_iter_i - 1'b1) begin
      w_done_q <= 1'b1;
    end
  end

  assign w_load_o     = load_w_go_i && !w_done_q;
  assign w_shift_o    = shift_go_i;
  assign w_done_o     = w_done_q;
  assign w_col_step_o = row_step && rows_last;

  assign w_height_o = (rows_last && w_rows_lftovr_i != '0) ?
                      w_rows_lftovr_i : iter_cnt_t'(Height);
  assign w_width_o  = (cols_last && w_cols_lftovr_i != '0) ?
                      w_cols_lftovr_i : iter_cnt_t'(Height);

endmodule

// ==== z_result_seq.sv ====
`timescale 1ns/1ns

module z_result_seq #(
  parameter int unsigned Width       = sched_pkg::ARRAY_WIDTH,
  parameter int unsigned Depth       = sched_pkg::TOT_DEPTH,
  parameter int unsigned NumPipeRegs = sched_pkg::PIPE_REGS
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                start_i,
  input  logic                z_empty_i,
  input  logic                w_col_step_i,
  input  logic                stall_i,
  input  logic                start_comp_i,
  input  logic                reg_enable_i,
  input  logic                w_done_i,
  input  sched_pkg::iter_cnt_t w_cols_iter_i,
  input  sched_pkg::iter_cnt_t w_rows_iter_i,
  input  sched_pkg::iter_cnt_t w_cols_lftovr_i,
  input  sched_pkg::iter_cnt_t w_rows_lftovr_i,
  output logic                z_y_push_o,
  output logic                z_fill_o,
  output logic                z_first_load_o,
  output logic                y_check_o,
  output logic                z_window_end_o,
  output sched_pkg::iter_cnt_t z_height_o,
  output sched_pkg::iter_cnt_t z_width_o
);

  import sched_pkg::*;

  localparam int unsigned WaitW = $clog2(NumPipeRegs + 1);

  iter_cnt_t        y_cols_q;
  iter_cnt_t        y_rows_q;
  iter_cnt_t        y_height;
  iter_cnt_t        y_width;
  iter_cnt_t        z_height_q;
  iter_cnt_t        z_width_q;
  iter_cnt_t        avail_cnt_q;
  iter_cnt_t        push_cnt_q;
  logic [WaitW-1:0] wait_cnt_q;
  logic             restart;
  logic             y_cols_last;
  logic             y_rows_last;
  logic             wait_en_q;
  logic             wait_end;
  logic             avail_en_q;
  logic             avail_end;
  logic             push_en_q;
  logic             push_open;
  logic             push_end;

  assign restart     = clear_i || start_i;
  assign y_cols_last = y_cols_q == w_cols_iter_i - 1'b1;
  assign y_rows_last = y_rows_q == w_rows_iter_i - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      y_cols_q <= '0;
      y_rows_q <= '0;
    end else if (restart) begin
      y_cols_q <= '0;
      y_rows_q <= '0;
    end else if (z_empty_i) begin
      y_cols_q <= y_cols_last ? '0 : y_cols_q + 1'b1;
      if (y_cols_last) begin
        y_rows_q <= y_rows_last ? '0 : y_rows_q + 1'b1;
      end
    end
  end

  // Results of a finished W column need the pipeline to drain first
  assign wait_end = wait_en_q && !stall_i && wait_cnt_q == WaitW'(NumPipeRegs);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_en_q  <= 1'b0;
      wait_cnt_q <= '0;
    end else if (restart) begin
      wait_en_q  <= 1'b0;
      wait_cnt_q <= '0;
    end else if (w_col_step_i) begin
      wait_en_q  <= 1'b1;
      wait_cnt_q <= '0;
    end else if (wait_en_q && !stall_i) begin
      wait_cnt_q <= wait_end ? '0 : wait_cnt_q + 1'b1;
      if (wait_end) begin
        wait_en_q <= 1'b0;
      end
    end
  end

  // Fill window, cut short when the next column starts draining
  assign avail_end = avail_en_q && !stall_i && avail_cnt_q == z_height_q - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      avail_en_q  <= 1'b0;
      avail_cnt_q <= '0;
    end else if (restart || w_col_step_i) begin
      avail_en_q  <= 1'b0;
      avail_cnt_q <= '0;
    end else if (wait_end) begin
      avail_en_q  <= 1'b1;
      avail_cnt_q <= '0;
    end else if (avail_en_q && !stall_i) begin
      avail_cnt_q <= avail_end ? '0 : avail_cnt_q + 1'b1;
      if (avail_end) begin
        avail_en_q <= 1'b0;
      end
    end
  end

  // New Y rows enter one cycle ahead of the fill window
  assign push_open = (wait_en_q && !stall_i && wait_cnt_q == WaitW'(NumPipeRegs - 1)) ||
                     start_comp_i;
  assign push_end  = push_en_q && !stall_i && push_cnt_q == y_height - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_en_q  <= 1'b0;
      push_cnt_q <= '0;
    end else if (restart) begin
      push_en_q  <= 1'b0;
      push_cnt_q <= '0;
    end else if (push_open) begin
      push_en_q  <= 1'b1;
      push_cnt_q <= '0;
    end else if (push_en_q && !stall_i) begin
      push_cnt_q <= push_end ? '0 : push_cnt_q + 1'b1;
      if (push_end) begin
        push_en_q <= 1'b0;
      end
    end
  end

  assign y_height = (y_cols_last && w_cols_lftovr_i != '0) ?
                    w_cols_lftovr_i : iter_cnt_t'(Depth);
  assign y_width  = (y_rows_last && w_rows_lftovr_i != '0) ?
                    w_rows_lftovr_i : iter_cnt_t'(Width);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      z_height_q <= '0;
      z_width_q  <= '0;
    end else if (clear_i) begin
      z_height_q <= '0;
      z_width_q  <= '0;
    end else if (z_empty_i || start_comp_i) begin
      z_height_q <= y_height;
      z_width_q  <= y_width;
    end
  end

  assign z_y_push_o     = push_en_q && !stall_i;
  assign z_fill_o       = avail_en_q && reg_enable_i;
  assign z_first_load_o = (y_cols_q == '0) && (y_rows_q == '0);
  assign y_check_o      = (wait_cnt_q == WaitW'(NumPipeRegs)) && !w_done_i;
  assign z_window_end_o = avail_end;
  assign z_height_o     = z_height_q;
  assign z_width_o      = z_width_q;

  // Draining and filling Z must never overlap
  a_fill_outside_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(z_fill_o && wait_en_q))
    else $error("z_fill_o high inside the drain window");

endmodule

// ==== gemm_scheduler.sv ====
`timescale 1ns/1ns

module gemm_scheduler #(
  parameter int unsigned Height      = sched_pkg::ARRAY_HEIGHT,
  parameter int unsigned Width       = sched_pkg::ARRAY_WIDTH,
  parameter int unsigned Depth       = sched_pkg::TOT_DEPTH,
  parameter int unsigned NumPipeRegs = sched_pkg::PIPE_REGS
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                start_i,
  input  logic                gemm_sel_i,
  input  logic                x_empty_i,
  input  logic                x_full_i,
  input  logic                x_valid_i,
  input  logic                w_valid_i,
  input  logic                z_empty_i,
  input  logic                z_loaded_i,
  input  sched_pkg::iter_cnt_t x_cols_iter_i,
  input  sched_pkg::iter_cnt_t x_rows_iter_i,
  input  sched_pkg::iter_cnt_t w_cols_iter_i,
  input  sched_pkg::iter_cnt_t w_rows_iter_i,
  input  sched_pkg::iter_cnt_t x_cols_lftovr_i,
  input  sched_pkg::iter_cnt_t x_rows_lftovr_i,
  input  sched_pkg::iter_cnt_t w_cols_lftovr_i,
  input  sched_pkg::iter_cnt_t w_rows_lftovr_i,
  output logic                reg_enable_o,
  output logic                busy_o,
  output logic                stall_o,
  output logic                pad_setup_o,
  output logic                w_loaded_o,
  output logic                x_load_o,
  output logic                x_h_shift_o,
  output logic                x_rst_w_index_o,
  output logic                x_last_o,
  output sched_pkg::iter_cnt_t x_height_o,
  output sched_pkg::iter_cnt_t x_width_o,
  output logic                w_load_o,
  output logic                w_shift_o,
  output logic                w_done_o,
  output sched_pkg::iter_cnt_t w_height_o,
  output sched_pkg::iter_cnt_t w_width_o,
  output logic                z_y_push_o,
  output logic                z_fill_o,
  output logic                z_first_load_o,
  output sched_pkg::iter_cnt_t z_height_o,
  output sched_pkg::iter_cnt_t z_width_o
);

  logic load_w_go;
  logic shift_go;
  logic start_comp;
  logic w_col_step;
  logic y_check;
  logic z_window_end;

  sched_phase_ctrl #(
    .NumPipeRegs(NumPipeRegs)
  ) u_phase_ctrl (
    .clk_i,
    .rst_ni,
    .clear_i,
    .start_i,
    .gemm_sel_i,
    .x_full_i,
    .z_loaded_i,
    .w_valid_i,
    .w_done_i      (w_done_o),
    .y_check_i     (y_check),
    .z_window_end_i(z_window_end),
    .load_w_go_o   (load_w_go),
    .shift_go_o    (shift_go),
    .pad_setup_o,
    .start_comp_o  (start_comp),
    .stall_o,
    .reg_enable_o,
    .busy_o,
    .w_loaded_o
  );

  x_tile_seq #(
    .Height(Height),
    .Width (Width),
    .Depth (Depth)
  ) u_x_tile_seq (
    .clk_i,
    .rst_ni,
    .clear_i,
    .start_i,
    .x_empty_i,
    .x_full_i,
    .x_valid_i,
    .shift_go_i (shift_go),
    .load_w_go_i(load_w_go),
    .stall_i    (stall_o),
    .x_cols_iter_i,
    .x_rows_iter_i,
    .w_cols_iter_i,
    .x_cols_lftovr_i,
    .x_rows_lftovr_i,
    .x_load_o,
    .x_h_shift_o,
    .x_rst_w_index_o,
    .x_last_o,
    .x_height_o,
    .x_width_o
  );

  w_tile_seq #(
    .Height(Height)
  ) u_w_tile_seq (
    .clk_i,
    .rst_ni,
    .clear_i,
    .start_i,
    .w_valid_i,
    .load_w_go_i (load_w_go),
    .shift_go_i  (shift_go),
    .w_rows_iter_i,
    .w_cols_iter_i,
    .x_rows_iter_i,
    .w_rows_lftovr_i,
    .w_cols_lftovr_i,
    .w_load_o,
    .w_shift_o,
    .w_done_o,
    .w_col_step_o(w_col_step),
    .w_height_o,
    .w_width_o
  );

  z_result_seq #(
    .Width      (Width),
    .Depth      (Depth),
    .NumPipeRegs(NumPipeRegs)
  ) u_z_result_seq (
    .clk_i,
    .rst_ni,
    .clear_i,
    .start_i,
    .z_empty_i,
    .w_col_step_i  (w_col_step),
    .stall_i       (stall_o),
    .start_comp_i  (start_comp),
    .reg_enable_i  (reg_enable_o),
    .w_done_i      (w_done_o),
    .w_cols_iter_i,
    .w_rows_iter_i,
    .w_cols_lftovr_i,
    .w_rows_lftovr_i,
    .z_y_push_o,
    .z_fill_o,
    .z_first_load_o,
    .y_check_o     (y_check),
    .z_window_end_o(z_window_end),
    .z_height_o,
    .z_width_o
  );

endmodule

// ==== tb_gemm_scheduler.sv ====
`timescale 1ns/1ns

module tb_gemm_scheduler;

  import sched_pkg::*;

  localparam int XColsIter   = 3;
  localparam int XRowsIter   = 2;
  localparam int WColsIter   = 2;
  localparam int WRowsIter   = 3;
  localparam int XColsLft    = 5;
  localparam int WColsLft    = 3;
  localparam int TotalLoads  = WRowsIter * WColsIter * XRowsIter;
  localparam int TotalXTiles = XColsIter * WColsIter * XRowsIter;
  localparam int EmptyPeriod = 12;
  // A full run takes about 100 cycles with gaps, two runs are made
  localparam int MaxCycles   = 2000;

  logic      clk_i      = 1'b0;
  logic      rst_ni     = 1'b0;
  logic      clear_i    = 1'b0;
  logic      start_i    = 1'b0;
  logic      gemm_sel_i = 1'b1;
  logic      x_empty_i  = 1'b0;
  logic      x_full_i   = 1'b0;
  logic      x_valid_i  = 1'b1;
  logic      w_valid_i  = 1'b0;
  logic      z_empty_i  = 1'b0;
  logic      z_loaded_i = 1'b0;
  iter_cnt_t x_cols_iter_i   = iter_cnt_t'(XColsIter);
  iter_cnt_t x_rows_iter_i   = iter_cnt_t'(XRowsIter);
  iter_cnt_t w_cols_iter_i   = iter_cnt_t'(WColsIter);
  iter_cnt_t w_rows_iter_i   = iter_cnt_t'(WRowsIter);
  iter_cnt_t x_cols_lftovr_i = iter_cnt_t'(XColsLft);
  iter_cnt_t x_rows_lftovr_i = '0;
  iter_cnt_t w_cols_lftovr_i = iter_cnt_t'(WColsLft);
  iter_cnt_t w_rows_lftovr_i = '0;

  logic      reg_enable_o, busy_o, stall_o, pad_setup_o, w_loaded_o;
  logic      x_load_o, x_h_shift_o, x_rst_w_index_o, x_last_o;
  logic      w_load_o, w_shift_o, w_done_o;
  logic      z_y_push_o, z_fill_o, z_first_load_o;
  iter_cnt_t x_height_o, x_width_o, w_height_o, w_width_o, z_height_o, z_width_o;

  integer    seed        = 32'hf65e2e0e;
  int        errors      = 0;
  int        cycle_cnt   = 0;
  logic      started     = 1'b0;
  logic      gaps_en     = 1'b1;
  logic      busy_q      = 1'b0;
  logic      load_seen_q = 1'b0;
  int        empty_timer = 0;
  int        load_cnt    = 0;
  int        empty_cnt   = 0;
  int        pad_cnt     = 0;
  int        w_row_ref   = 0;
  int        w_col_ref   = 0;
  int        gap_cnt     = 0;
  logic      have_prev   = 1'b0;
  logic      stalled_since = 1'b0;
  iter_cnt_t fill_run    = '0;
  iter_cnt_t x_height_exp;
  logic      in_load_w;
  logic      w_gap;
  logic [10:0] idle_outputs;

  gemm_scheduler dut_i (
    .clk_i, .rst_ni, .clear_i, .start_i, .gemm_sel_i,
    .x_empty_i, .x_full_i, .x_valid_i, .w_valid_i, .z_empty_i, .z_loaded_i,
    .x_cols_iter_i, .x_rows_iter_i, .w_cols_iter_i, .w_rows_iter_i,
    .x_cols_lftovr_i, .x_rows_lftovr_i, .w_cols_lftovr_i, .w_rows_lftovr_i,
    .reg_enable_o, .busy_o, .stall_o, .pad_setup_o, .w_loaded_o,
    .x_load_o, .x_h_shift_o, .x_rst_w_index_o, .x_last_o, .x_height_o, .x_width_o,
    .w_load_o, .w_shift_o, .w_done_o, .w_height_o, .w_width_o,
    .z_y_push_o, .z_fill_o, .z_first_load_o, .z_height_o, .z_width_o
  );

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
  endtask

  // One GEMM job from the start pulse until busy_o drops
  task automatic run_job(input logic with_gaps);
    gaps_en <= with_gaps;
    @(posedge clk_i);
    start_i <= 1'b1;
    started <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    @(posedge clk_i);
    while (busy_o) begin
      @(posedge clk_i);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout after %0d cycles, busy_o never returned low", MaxCycles);
      $display("checks done with %0d errors", errors);
      $display("test failed");
      $finish;
    end
  end

  // Random gaps in the W stream and late Y rows, only in the first job
  always @(posedge clk_i) begin
    if (rst_ni && gaps_en) begin
      w_valid_i  <= ($random(seed) % 4) != 0;
      z_loaded_i <= ($random(seed) % 8) != 0;
    end else begin
      w_valid_i  <= rst_ni;
      z_loaded_i <= rst_ni;
    end
  end

  // X buffer: full two cycles after a refill write, drained every few cycles
  always @(posedge clk_i) begin
    load_seen_q <= x_load_o;
    x_empty_i   <= 1'b0;
    if (load_seen_q) begin
      x_full_i <= 1'b1;
    end
    if (busy_o && x_full_i && !x_empty_i && empty_timer >= EmptyPeriod - 1 &&
        empty_cnt < TotalXTiles) begin
      x_empty_i   <= 1'b1;
      x_full_i    <= 1'b0;
      empty_timer <= 0;
    end else if (empty_timer < EmptyPeriod) begin
      empty_timer <= empty_timer + 1;
    end
  end

  // Reference counts of W loads, W columns and drained X tiles
  always @(posedge clk_i) begin
    busy_q   <= busy_o;
    fill_run <= z_fill_o ? fill_run + 1'b1 : '0;
    if (start_i && !busy_o) begin
      load_cnt      <= 0;
      empty_cnt     <= 0;
      pad_cnt       <= 0;
      w_row_ref     <= 0;
      w_col_ref     <= 0;
      have_prev     <= 1'b0;
      stalled_since <= 1'b0;
    end else begin
      if (w_load_o) begin
        load_cnt      <= load_cnt + 1;
        have_prev     <= 1'b1;
        gap_cnt       <= 1;
        stalled_since <= 1'b0;
        w_row_ref     <= (w_row_ref == WRowsIter - 1) ? 0 : w_row_ref + 1;
        if (w_row_ref == WRowsIter - 1) begin
          w_col_ref <= (w_col_ref == WColsIter - 1) ? 0 : w_col_ref + 1;
        end
      end else begin
        gap_cnt <= gap_cnt + 1;
        if (stall_o) begin
          stalled_since <= 1'b1;
        end
      end
      if (x_empty_i) begin
        empty_cnt <= empty_cnt + 1;
      end
      if (pad_setup_o) begin
        pad_cnt <= pad_cnt + 1;
      end
    end
  end

  assign in_load_w    = dut_i.u_phase_ctrl.phase_q == LOAD_W;
  assign w_gap        = in_load_w && !w_valid_i && load_cnt < TotalLoads;
  assign x_height_exp = (empty_cnt % XColsIter == XColsIter - 1) ?
                        iter_cnt_t'(XColsLft) : iter_cnt_t'(TOT_DEPTH);
  assign idle_outputs = {reg_enable_o, busy_o, w_load_o, w_shift_o, w_loaded_o, x_load_o,
                         x_h_shift_o, x_rst_w_index_o, x_last_o, z_y_push_o, z_fill_o};

  a_idle_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !started |-> idle_outputs == '0)
    else report_mismatch("idle outputs", 32'(idle_outputs), 32'h0);

  a_load_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (w_load_o && have_prev && !stalled_since) |-> gap_cnt == PIPE_REGS + 1)
    else report_mismatch("w_load_o spacing", 32'(gap_cnt), 32'(PIPE_REGS + 1));

  a_gap_blocks_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_gap |-> !w_load_o)
    else report_mismatch("w_load_o", 32'(w_load_o), 32'h0);

  a_gap_stalls: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_gap |-> stall_o)
    else report_mismatch("stall_o", 32'(stall_o), 32'h1);

  a_gap_drops_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_gap |=> !reg_enable_o)
    else report_mismatch("reg_enable_o", 32'(reg_enable_o), 32'h0);

  a_load_total: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (busy_q && !busy_o) |-> load_cnt == TotalLoads)
    else report_mismatch("w_load_o count", 32'(load_cnt), 32'(TotalLoads));

  a_pad_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (busy_q && !busy_o) |-> pad_cnt == 1)
    else report_mismatch("pad_setup_o count", 32'(pad_cnt), 32'h1);

  // W is done exactly once every load of the job has been issued
  a_w_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_done_o == (load_cnt == TotalLoads))
    else report_mismatch("w_done_o", 32'(w_done_o), 32'(load_cnt == TotalLoads));

  a_w_width_lftovr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (w_col_ref == WColsIter - 1) |-> w_width_o == w_cols_lftovr_i)
    else report_mismatch("w_width_o", 32'(w_width_o), 32'(w_cols_lftovr_i));

  // Row leftovers are zero, so these sizes stay at the full tile
  a_w_height: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_height_o == iter_cnt_t'(ARRAY_HEIGHT))
    else report_mismatch("w_height_o", 32'(w_height_o), 32'(ARRAY_HEIGHT));

  a_x_width: assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_width_o == iter_cnt_t'(ARRAY_WIDTH))
    else report_mismatch("x_width_o", 32'(x_width_o), 32'(ARRAY_WIDTH));

  a_x_height: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (empty_cnt < TotalXTiles) |-> x_height_o == x_height_exp)
    else report_mismatch("x_height_o", 32'(x_height_o), 32'(x_height_exp));

  a_fill_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
    z_fill_o |-> fill_run < z_height_o)
    else report_mismatch("z_fill_o run length", 32'(fill_run + 1'b1), 32'(z_height_o));

  a_z_width: assert property (@(posedge clk_i) disable iff (!rst_ni)
    z_fill_o |-> z_width_o == iter_cnt_t'(ARRAY_WIDTH))
    else report_mismatch("z_width_o", 32'(z_width_o), 32'(ARRAY_WIDTH));

  // No Z tile is ever drained, so the Y/Z counters stay on the first tile
  a_z_first_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
    z_first_load_o)
    else report_mismatch("z_first_load_o", 32'(z_first_load_o), 32'h1);

  a_push_not_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stall_o || w_gap) |-> !z_y_push_o)
    else report_mismatch("z_y_push_o", 32'(z_y_push_o), 32'h0);

  initial begin
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(posedge clk_i);
    run_job(1'b1);
    repeat (4) @(posedge clk_i);
    run_job(1'b0);
    repeat (4) @(posedge clk_i);
    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
sched_pkg.sv
sched_phase_ctrl.sv
x_tile_seq.sv
w_tile_seq.sv
z_result_seq.sv
gemm_scheduler.sv
tb_gemm_scheduler.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_gemm_scheduler -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "test passed" &&
echo "simulation ok" || { echo "simulation not ok"; exit 1; }
